// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module conTb -Mdir obj_dir

./obj_dir/VconTb > sim.log
cat sim.log

if grep -q "^Result: PASSED$" sim.log; then
  exit 0
else
  exit 1
fi

// ==== src/con.sv ====
`timescale 1ns/1ps
`default_nettype none

module con (
  input  logic                CON_CLK,
  input  logic                rstN,
  input  conPkg::microWord_t  microWord,
  input  conPkg::mclStatus_t  mcl,
  input  conPkg::modeStatus_t mode,
  input  logic                pageError,
  input  logic                fmXferIn,
  input  logic                diagStrobe,
  input  conPkg::diagFunc_t   diagCode,
  input  logic                piReady,
  input  logic                mtrIntReq,
  output logic                skip,
  output logic                run,
  output logic                start,
  output logic                memCycle,
  output logic                piCycle,
  output logic                mboxWait,
  output logic                fmXfer,
  output logic                loadIr,
  output logic                intReq,
  output logic                ioLegal,
  output conPkg::specFlags_t  flags
);

  conPkg::condEnables_t condEn;
  logic kernelMode;
  logic diagIrStrobeOut;

  conCondDecode condDecode_i (
    .microWord(microWord),
    .condEn   (condEn)
  );

  conRunControl runControl_i (
    .CON_CLK        (CON_CLK),
    .rstN           (rstN),
    .diagStrobe     (diagStrobe),
    .diagCode       (diagCode),
    .run            (run),
    .start          (start),
    .diagIrStrobeOut(diagIrStrobeOut)
  );

  conSpecInstr specInstr_i (
    .CON_CLK   (CON_CLK),
    .rstN      (rstN),
    .condEn    (condEn),
    .magic     (microWord.magic),
    .mode      (mode),
    .piReady   (piReady),
    .mtrIntReq (mtrIntReq),
    .flags     (flags),
    .kernelMode(kernelMode),
    .ioLegal   (ioLegal),
    .intReq    (intReq)
  );

  conCycleTrack cycleTrack_i (
    .CON_CLK        (CON_CLK),
    .rstN           (rstN),
    .condEn         (condEn),
    .microWord      (microWord),
    .mcl            (mcl),
    .pageError      (pageError),
    .fmXferIn       (fmXferIn),
    .diagIrStrobeOut(diagIrStrobeOut),
    .memCycle       (memCycle),
    .piCycle        (piCycle),
    .mboxWait       (mboxWait),
    .fmXfer         (fmXfer),
    .loadIr         (loadIr)
  );

  conSkipSelect skipSelect_i (
    .condEn    (condEn),
    .cond      (microWord.cond),
    .mcl       (mcl),
    .mode      (mode),
    .kernelMode(kernelMode),
    .piCycle   (piCycle),
    .run       (run),
    .start     (start),
    .intReq    (intReq),
    .ioLegal   (ioLegal),
    .pxct      (flags.pxct),
    .skip      (skip)
  );

endmodule

`default_nettype wire

// ==== src/conCondDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module conCondDecode (
  input  conPkg::microWord_t   microWord,
  output conPkg::condEnables_t condEn
);

  conPkg::condSel_t grp;
  conPkg::condSel_t func;
  logic grp10En;
  logic diagGrpEn;
  logic grp60En;
  logic grp70En;

  // Upper three bits pick the group, lower three the function
  assign grp = microWord.cond[conPkg::condW-1 -: conPkg::condSelW];
  assign func = microWord.cond[conPkg::condSelW-1:0];

  assign grp10En = (grp == conPkg::condGrp10);
  assign diagGrpEn = (grp == conPkg::condDiagFuncGrp);
  assign grp60En = (grp == conPkg::condGrp60);
  assign grp70En = (grp == conPkg::condGrp70);

  always_comb begin
    condEn = '0;

    // Group 1 carries the named microword conditions
    if (grp10En) begin
      case (func)
        conPkg::condLoadIrCode: begin
          condEn.loadIr = 1'b1;
        end
        conPkg::condSpecInstrCode: begin
          condEn.specInstr = 1'b1;
        end
        conPkg::condSrMagicCode: begin
          condEn.srMagic = 1'b1;
        end
        conPkg::condSelVmaCode: begin
          condEn.selVma = 1'b1;
        end
        default: begin
          condEn.loadIr = 1'b0;
        end
      endcase
    end

    // Diagnostic function is a single code in group 2
    if (diagGrpEn && (func == conPkg::condDiagFuncCode)) begin
      condEn.diagFunc = 1'b1;
    end

    // Skip groups take the whole group, function picks the condition later
    condEn.skipEn6x = grp60En;
    condEn.skipEn7x = grp70En;
  end

endmodule

`default_nettype wire

// ==== src/conCycleTrack.sv ====
`timescale 1ns/1ps
`default_nettype none

module conCycleTrack (
  input  logic                 CON_CLK,
  input  logic                 rstN,
  input  conPkg::condEnables_t condEn,
  input  conPkg::microWord_t   microWord,
  input  conPkg::mclStatus_t   mcl,
  input  logic                 pageError,
  input  logic                 fmXferIn,
  input  logic                 diagIrStrobeOut,
  output logic                 memCycle,
  output logic                 piCycle,
  output logic                 mboxWait,
  output logic                 fmXfer,
  output logic                 loadIr
);

  logic xfer;
  logic fetchCycle;
  logic setPiCycle;
  logic clrPiCycle;

  assign mboxWait = memCycle && microWord.mem[conPkg::memWaitBit];
  assign fmXfer = fmXferIn && mboxWait;
  assign xfer = fmXfer || mcl.mbXfer;
  assign fetchCycle = memCycle && mcl.vmaFetch;
  assign loadIr = fetchCycle || condEn.loadIr || diagIrStrobeOut;

  assign setPiCycle = condEn.specInstr && microWord.magic[conPkg::magicPiCycle];
  assign clrPiCycle = mcl.skipSatisfied ||
                      (condEn.diagFunc && microWord.magic[conPkg::magicClrPiCycle]);

  // A new request keeps the cycle open across a finishing transfer
  always_ff @(posedge CON_CLK or negedge rstN) begin
    if (!rstN) begin
      memCycle <= 1'b0;
    end else begin
      memCycle <= mcl.mboxCycReq || (memCycle && !xfer && !pageError);
    end
  end

  always_ff @(posedge CON_CLK or negedge rstN) begin
    if (!rstN) begin
      piCycle <= 1'b0;
    end else begin
      piCycle <= setPiCycle || (piCycle && !clrPiCycle);
    end
  end

  // Wait only inside a cycle opened on an earlier edge
  waitInMemCycle: assert property (
    @(posedge CON_CLK) disable iff (!rstN)
    mboxWait |-> $past(mcl.mboxCycReq || memCycle)
  );

endmodule

`default_nettype wire

// ==== src/conPkg.sv ====
`default_nettype none

package conPkg;

  // Microword field widths
  localparam int condW = 6;
  localparam int condSelW = 3;
  localparam int magicW = 9;
  localparam int memW = 3;
  localparam int diagFuncW = 3;

  // Run and start synchronizer depth
  localparam int runSyncStages = 3;

  typedef logic [condW-1:0] condField_t;
  typedef logic [condSelW-1:0] condSel_t;
  typedef logic [0:magicW-1] magicField_t;
  typedef logic [memW-1:0] memField_t;
  typedef logic [diagFuncW-1:0] diagFunc_t;

  // Bit positions inside the magic and mem fields
  localparam int magicPiCycle = 0;
  localparam int magicKernelCycle = 1;
  localparam int magicPcPlus1Inh = 2;
  localparam int magicClrPiCycle = 2;
  localparam int magicPxct = 4;
  localparam int magicIntDisable = 5;
  localparam int magicEboxHalted = 7;
  localparam int memWaitBit = 2;

  // Condition groups, upper half of the cond field
  localparam condSel_t condGrp10 = 3'd1;
  localparam condSel_t condGrp60 = 3'd6;
  localparam condSel_t condGrp70 = 3'd7;
  localparam condSel_t condDiagFuncGrp = 3'd2;

  // Functions within a group
  localparam condSel_t condLoadIrCode = 3'd4;
  localparam condSel_t condSpecInstrCode = 3'd5;
  localparam condSel_t condSrMagicCode = 3'd6;
  localparam condSel_t condSelVmaCode = 3'd7;
  localparam condSel_t condDiagFuncCode = 3'd0;

  // Diagnostic console functions
  localparam diagFunc_t diagClrRun = 3'd0;
  localparam diagFunc_t diagSetRun = 3'd1;
  localparam diagFunc_t diagContinue = 3'd2;
  localparam diagFunc_t diagIrStrobe = 3'd4;

  typedef struct packed {
    condField_t  cond;
    magicField_t magic;
    memField_t   mem;
  } microWord_t;

  typedef struct packed {
    logic loadIr;
    logic specInstr;
    logic srMagic;
    logic diagFunc;
    logic skipEn6x;
    logic skipEn7x;
    logic selVma;
  } condEnables_t;

  typedef struct packed {
    logic kernelCycle;
    logic pcPlus1Inh;
    logic pxct;
    logic intDisable;
    logic eboxHalted;
  } specFlags_t;

  typedef struct packed {
    logic mboxCycReq;
    logic vmaFetch;
    logic skipSatisfied;
    logic loadAr;
    logic loadArx;
    logic mbXfer;
  } mclStatus_t;

  typedef struct packed {
    logic user;
    logic userIot;
    logic public;
    logic irIoLegal;
  } modeStatus_t;

endpackage

`default_nettype wire

// ==== src/conRunControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module conRunControl (
  input  logic              CON_CLK,
  input  logic              rstN,
  input  logic              diagStrobe,
  input  conPkg::diagFunc_t diagCode,
  output logic              run,
  output logic              start,
  output logic              diagIrStrobeOut
);

  logic doClrRun;
  logic doSetRun;
  logic doContinue;
  logic runState;
  logic contReq;
  logic [conPkg::runSyncStages-1:0] runSync;
  logic [conPkg::runSyncStages-1:0] startSync;

  // Console function decode
  assign doClrRun = diagStrobe && (diagCode == conPkg::diagClrRun);
  assign doSetRun = diagStrobe && (diagCode == conPkg::diagSetRun);
  assign doContinue = diagStrobe && (diagCode == conPkg::diagContinue);
  assign diagIrStrobeOut = diagStrobe && (diagCode == conPkg::diagIrStrobe);

  always_ff @(posedge CON_CLK or negedge rstN) begin
    if (!rstN) begin
      runState <= 1'b0;
      contReq <= 1'b0;
    end else begin
      if (doSetRun) begin
        runState <= 1'b1;
      end else if (doClrRun) begin
        runState <= 1'b0;
      end
      // Back-to-back continues still give separate pulses
      contReq <= doContinue && !contReq;
    end
  end

  // Console side to EBOX clock domain
  always_ff @(posedge CON_CLK or negedge rstN) begin
    if (!rstN) begin
      runSync <= '0;
      startSync <= '0;
    end else begin
      runSync <= {runSync[conPkg::runSyncStages-2:0], runState};
      startSync <= {startSync[conPkg::runSyncStages-2:0], contReq};
    end
  end

  assign run = runSync[conPkg::runSyncStages-1];
  assign start = startSync[conPkg::runSyncStages-1];

  startOnePulse: assert property (
    @(posedge CON_CLK) disable iff (!rstN)
    start |=> !start
  );

endmodule

`default_nettype wire

// ==== src/conSkipSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

module conSkipSelect (
  input  conPkg::condEnables_t condEn,
  input  conPkg::condField_t   cond,
  input  conPkg::mclStatus_t   mcl,
  input  conPkg::modeStatus_t  mode,
  input  logic                 kernelMode,
  input  logic                 piCycle,
  input  logic                 run,
  input  logic                 start,
  input  logic                 intReq,
  input  logic                 ioLegal,
  input  logic                 pxct,
  output logic                 skip
);

  conPkg::condSel_t func;
  logic skip6x;
  logic skip7x;

  assign func = cond[conPkg::condSelW-1:0];

  // 6x group
  always_comb begin
    case (func)
      3'd0: skip6x = mcl.vmaFetch;
      3'd1: skip6x = kernelMode;
      3'd2: skip6x = mode.user;
      3'd3: skip6x = mode.public;
      3'd4: skip6x = piCycle;
      3'd5: skip6x = !run;
      default: skip6x = 1'b0;
    endcase
  end

  // 7x group
  always_comb begin
    case (func)
      3'd0: skip7x = intReq;
      3'd1: skip7x = !start;
      3'd2: skip7x = run;
      3'd3: skip7x = ioLegal;
      3'd4: skip7x = pxct;
      default: skip7x = 1'b0;
    endcase
  end

  assign skip = (condEn.skipEn6x && skip6x) || (condEn.skipEn7x && skip7x);

endmodule

`default_nettype wire

// ==== src/conSpecInstr.sv ====
`timescale 1ns/1ps
`default_nettype none

module conSpecInstr (
  input  logic                 CON_CLK,
  input  logic                 rstN,
  input  conPkg::condEnables_t condEn,
  input  conPkg::magicField_t  magic,
  input  conPkg::modeStatus_t  mode,
  input  logic                 piReady,
  input  logic                 mtrIntReq,
  output conPkg::specFlags_t   flags,
  output logic                 kernelMode,
  output logic                 ioLegal,
  output logic                 intReq
);

  logic intPending;

  // Flags taken from the magic field on a special instruction
  always_ff @(posedge CON_CLK or negedge rstN) begin
    if (!rstN) begin
      flags <= '0;
    end else if (condEn.specInstr) begin
      flags.kernelCycle <= magic[conPkg::magicKernelCycle];
      flags.pcPlus1Inh <= magic[conPkg::magicPcPlus1Inh];
      flags.pxct <= magic[conPkg::magicPxct];
      flags.intDisable <= magic[conPkg::magicIntDisable];
      flags.eboxHalted <= magic[conPkg::magicEboxHalted];
    end
  end

  // PI and meter requests arrive from other boards, sample once
  always_ff @(posedge CON_CLK or negedge rstN) begin
    if (!rstN) begin
      intPending <= 1'b0;
    end else begin
      intPending <= piReady || mtrIntReq;
    end
  end

  assign intReq = intPending && !flags.intDisable;

  assign kernelMode = !mode.user && !mode.public;

  // IO instructions also legal for user with IOT privilege
  assign ioLegal = mode.irIoLegal || kernelMode || flags.kernelCycle ||
                   (mode.user && mode.userIot);

  flagsHoldOtherwise: assert property (
    @(posedge CON_CLK) disable iff (!rstN)
    !condEn.specInstr |=> $stable(flags)
  );

endmodule

`default_nettype wire

// ==== verification/conModel.svh ====
`ifndef CON_MODEL_SVH
`define CON_MODEL_SVH

// Reference state, advanced once per rising clock edge
conPkg::specFlags_t mFlags;
logic [conPkg::runSyncStages:0] runHist;
logic [conPkg::runSyncStages:0] startHist;
logic runTarget;
logic mMemCycle;
logic mPiCycle;
logic mIntPending;

task automatic modelReset();
  mFlags = '0;
  runHist = '0;
  startHist = '0;
  runTarget = 1'b0;
  mMemCycle = 1'b0;
  mPiCycle = 1'b0;
  mIntPending = 1'b0;
endtask

function automatic logic kernelNow();
  return !mode.user && !mode.public;
endfunction

function automatic logic ioLegalNow();
  return mode.irIoLegal || kernelNow() || mFlags.kernelCycle || (mode.user && mode.userIot);
endfunction

function automatic logic intReqNow();
  return mIntPending && !mFlags.intDisable;
endfunction

function automatic logic waitNow();
  return mMemCycle && microWord.mem[2];
endfunction

function automatic logic xferNow();
  return fmXferIn && waitNow();
endfunction

function automatic logic irLoadNow();
  // Fetch, condition 14 or console IR strobe
  return (mMemCycle && mcl.vmaFetch) || (microWord.cond == 6'o14) ||
         (diagStrobe && (diagCode == 3'd4));
endfunction

task automatic modelStep();
  logic specInstr;
  logic diagFn;
  logic anyXfer;
  specInstr = (microWord.cond == 6'o15);
  diagFn = (microWord.cond == 6'o20);
  anyXfer = xferNow() || mcl.mbXfer || pageError;
  if (diagStrobe && (diagCode == 3'd1)) begin
    runTarget = 1'b1;
  end else if (diagStrobe && (diagCode == 3'd0)) begin
    runTarget = 1'b0;
  end
  // Output end of each history sits runSyncStages edges behind the strobe
  runHist = {runHist[conPkg::runSyncStages-1:0], runTarget};
  startHist = {startHist[conPkg::runSyncStages-1:0], diagStrobe && (diagCode == 3'd2)};
  mPiCycle = (specInstr && microWord.magic[0]) ||
             (mPiCycle && !(mcl.skipSatisfied || (diagFn && microWord.magic[2])));
  mMemCycle = mcl.mboxCycReq || (mMemCycle && !anyXfer);
  if (specInstr) begin
    mFlags.kernelCycle = microWord.magic[1];
    mFlags.pcPlus1Inh = microWord.magic[2];
    mFlags.pxct = microWord.magic[4];
    mFlags.intDisable = microWord.magic[5];
    mFlags.eboxHalted = microWord.magic[7];
  end
  mIntPending = piReady || mtrIntReq;
endtask

function automatic logic skipNow();
  logic [2:0] fn;
  logic hit;
  fn = microWord.cond[2:0];
  hit = 1'b0;
  if (microWord.cond[5:3] == 3'd6) begin
    case (fn)
      3'd0: hit = mcl.vmaFetch;
      3'd1: hit = kernelNow();
      3'd2: hit = mode.user;
      3'd3: hit = mode.public;
      3'd4: hit = mPiCycle;
      3'd5: hit = !runHist[conPkg::runSyncStages];
      default: hit = 1'b0;
    endcase
  end else if (microWord.cond[5:3] == 3'd7) begin
    case (fn)
      3'd0: hit = intReqNow();
      3'd1: hit = !startHist[conPkg::runSyncStages];
      3'd2: hit = runHist[conPkg::runSyncStages];
      3'd3: hit = ioLegalNow();
      3'd4: hit = mFlags.pxct;
      default: hit = 1'b0;
    endcase
  end
  return hit;
endfunction

`endif

// ==== verification/conTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module conTb;

  localparam int clkPeriod = 8;
  localparam int resetCycles = 4;
  localparam int numCycles = 3000;

  logic CON_CLK;
  logic rstN;
  conPkg::microWord_t microWord;
  conPkg::mclStatus_t mcl;
  conPkg::modeStatus_t mode;
  logic pageError;
  logic fmXferIn;
  logic diagStrobe;
  conPkg::diagFunc_t diagCode;
  logic piReady;
  logic mtrIntReq;

  logic skip;
  logic run;
  logic start;
  logic memCycle;
  logic piCycle;
  logic mboxWait;
  logic fmXfer;
  logic loadIr;
  logic intReq;
  logic ioLegal;
  conPkg::specFlags_t flags;

  integer seed = 32'h5d7e;
  int errorCount = 0;
  int checkCount = 0;
  logic checking;

  `include "conModel.svh"

  con dut_i (
    .CON_CLK(CON_CLK), .rstN(rstN), .microWord(microWord), .mcl(mcl), .mode(mode),
    .pageError(pageError), .fmXferIn(fmXferIn), .diagStrobe(diagStrobe),
    .diagCode(diagCode), .piReady(piReady), .mtrIntReq(mtrIntReq), .skip(skip),
    .run(run), .start(start), .memCycle(memCycle), .piCycle(piCycle),
    .mboxWait(mboxWait), .fmXfer(fmXfer), .loadIr(loadIr), .intReq(intReq),
    .ioLegal(ioLegal), .flags(flags)
  );

  always #(clkPeriod / 2) CON_CLK = ~CON_CLK;

  task automatic checkBit(input string name, input logic expected, input logic actual);
    checkCount++;
    assert (actual === expected) else begin
      errorCount++;
      $display("Mismatch %s at %0t: expected %0b, actual %0b", name, $time, expected, actual);
    end
  endtask

  task automatic checkFlags(input string name, input conPkg::specFlags_t expected,
                            input conPkg::specFlags_t actual);
    checkCount++;
    assert (actual === expected) else begin
      errorCount++;
      $display("Mismatch %s at %0t: expected %b, actual %b", name, $time, expected, actual);
    end
  endtask

  task automatic driveRandom();
    logic [31:0] r;
    r = $random(seed);
    microWord.cond = r[5:0];
    // Favor the groups that do something
    if (r[31]) begin
      case (r[30:29])
        2'd0: microWord.cond[5:3] = 3'd1;
        2'd1: microWord.cond[5:3] = 3'd2;
        2'd2: microWord.cond[5:3] = 3'd6;
        default: microWord.cond[5:3] = 3'd7;
      endcase
    end
    microWord.magic = r[14:6];
    microWord.mem = r[17:15];
    mode = r[21:18];
    fmXferIn = r[22];
    pageError = (r[25:23] == 3'd0);
    r = $random(seed);
    mcl = r[5:0];
    mcl.mboxCycReq = (r[7:6] == 2'd0);
    mcl.skipSatisfied = (r[10:8] == 3'd0);
    piReady = r[11] && r[12];
    mtrIntReq = r[13] && r[14] && r[15];
    // Never two strobes in a row
    diagStrobe = !diagStrobe && (r[18:16] == 3'd0);
    diagCode = r[21:19];
  endtask

  task automatic checkOutputs();
    checkBit("skip select", skipNow(), skip);
    checkBit("run", runHist[conPkg::runSyncStages], run);
    checkBit("start", startHist[conPkg::runSyncStages], start);
    checkBit("memCycle", mMemCycle, memCycle);
    checkBit("piCycle", mPiCycle, piCycle);
    checkBit("mboxWait", waitNow(), mboxWait);
    checkBit("fmXfer", xferNow(), fmXfer);
    checkBit("loadIr", irLoadNow(), loadIr);
    checkBit("intReq", intReqNow(), intReq);
    checkBit("ioLegal", ioLegalNow(), ioLegal);
    checkFlags("flags", mFlags, flags);
  endtask

  always @(posedge CON_CLK or negedge rstN) begin
    if (!rstN) begin
      modelReset();
    end else begin
      modelStep();
    end
  end

  always @(negedge CON_CLK) begin
    if (checking) begin
      checkOutputs();
    end
  end

  initial begin
    CON_CLK = 1'b0;
    rstN = 1'b0;
    checking = 1'b0;
    microWord = '0;
    mcl = '0;
    mode = '0;
    pageError = 1'b0;
    fmXferIn = 1'b0;
    diagStrobe = 1'b0;
    diagCode = '0;
    piReady = 1'b0;
    mtrIntReq = 1'b0;
    modelReset();
    repeat (resetCycles) @(posedge CON_CLK);
    @(negedge CON_CLK);
    checkBit("reset run", 1'b0, run);
    checkBit("reset start", 1'b0, start);
    checkBit("reset memCycle", 1'b0, memCycle);
    checkBit("reset piCycle", 1'b0, piCycle);
    checkBit("reset intReq", 1'b0, intReq);
    checkBit("reset skip", 1'b0, skip);
    checkFlags("reset flags", '0, flags);
    @(posedge CON_CLK);
    #1;
    rstN = 1'b1;
    checking = 1'b1;
    repeat (numCycles) begin
      driveRandom();
      @(posedge CON_CLK);
      #1;
    end
    checking = 1'b0;
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #((resetCycles + numCycles + 20) * clkPeriod);
    $display("Timeout: the stimulus did not complete in the expected time");
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verification
src/conPkg.sv
src/conCondDecode.sv
src/conRunControl.sv
src/conSpecInstr.sv
src/conCycleTrack.sv
src/conSkipSelect.sv
src/con.sv
verification/conTb.sv
